// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_axi_intr_monitor
RTL_TOP    := axi_intr_monitor
FILELIST   := axi_intr_monitor.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

# Lint the design from its top level
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build and run the testbench, the log decides pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== axi_intr_monitor.f ====
+incdir+verif
common/intr_mon_regs_pkg.sv
common/intr_mon_types_pkg.sv
common/up_bus_if.sv
common/intr_timer_if.sv
up_axi/up_axi_bridge.sv
rtl/intr_mon_regs.sv
rtl/intr_mon_timer.sv
rtl/axi_intr_monitor.sv
verif/tb_axi_intr_monitor.sv

// ==== common/intr_mon_regs_pkg.sv ====
package intr_mon_regs_pkg;

  // ********************
  // Bus widths
  // ********************

  // AXI byte address and register data widths
  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam int prot_width = 3;

  // The word address covers byte address bits 15 down to 2
  localparam int up_addr_width = 14;

  // Only the low word address bits take part in the register decode
  localparam int reg_sel_width = 4;

  // Core identification word returned by the first register
  localparam logic [data_width-1:0] version_value = 32'h0001_0000;

  // ********************
  // Register map
  // ********************

  localparam logic [reg_sel_width-1:0] reg_version       = 4'h0;
  localparam logic [reg_sel_width-1:0] reg_scratch       = 4'h1;
  localparam logic [reg_sel_width-1:0] reg_control       = 4'h2;
  localparam logic [reg_sel_width-1:0] reg_status        = 4'h3;
  localparam logic [reg_sel_width-1:0] reg_count_load    = 4'h4;
  localparam logic [reg_sel_width-1:0] reg_since_irq     = 4'h5;
  localparam logic [reg_sel_width-1:0] reg_handling_last = 4'h6;
  localparam logic [reg_sel_width-1:0] reg_handling_min  = 4'h7;
  localparam logic [reg_sel_width-1:0] reg_handling_max  = 4'h8;

  // The bus always answers OKAY
  localparam logic [1:0] resp_okay = 2'b00;

endpackage

// ==== common/intr_mon_types_pkg.sv ====
package intr_mon_types_pkg;

  // ********************
  // Counter sizing
  // ********************

  // Every counter in the timer stage has this width, which covers the
  // countdown, the cycles since the last interrupt and the three
  // handling-time statistics
  localparam int cnt_width = 32;

  // ********************
  // Statistic reset values
  // ********************

  // The minimum starts at all ones so that the first recorded handling
  // time always replaces it
  localparam logic [cnt_width-1:0] min_reset_value = '1;

  // The maximum starts at zero so that the first event replaces it too
  localparam logic [cnt_width-1:0] max_reset_value = '0;

endpackage

// ==== common/intr_timer_if.sv ====
`timescale 1ns/100ps

// Control and statistics between the register bank and the timer stage
interface intr_timer_if;

  // Control from the register bank
  logic                                    enable;
  logic                                    arm;
  logic [intr_mon_types_pkg::cnt_width-1:0] load_value;
  logic                                    irq;

  // Status and statistics from the timer
  logic                                    expired;
  logic [intr_mon_types_pkg::cnt_width-1:0] since_irq;
  logic [intr_mon_types_pkg::cnt_width-1:0] handling_last;
  logic [intr_mon_types_pkg::cnt_width-1:0] handling_min;
  logic [intr_mon_types_pkg::cnt_width-1:0] handling_max;

  // Register bank side
  modport regs (
    output enable, arm, load_value, irq,
    input  expired, since_irq, handling_last, handling_min, handling_max
  );

  // Timer side
  modport timer (
    input  enable, arm, load_value, irq,
    output expired, since_irq, handling_last, handling_min, handling_max
  );

endinterface

// ==== common/up_bus_if.sv ====
`timescale 1ns/100ps

// Internal register bus between the AXI bridge and the register bank
interface up_bus_if;

  // Write request, one-cycle pulse with its word address and data
  logic                                     wreq;
  logic [intr_mon_regs_pkg::up_addr_width-1:0] waddr;
  logic [intr_mon_regs_pkg::data_width-1:0]    wdata;
  logic                                     wack;

  // Read request, one-cycle pulse with its word address
  logic                                     rreq;
  logic [intr_mon_regs_pkg::up_addr_width-1:0] raddr;
  logic [intr_mon_regs_pkg::data_width-1:0]    rdata;
  logic                                     rack;

  // The bridge raises requests and waits for the acknowledges
  modport bridge (
    output wreq, waddr, wdata, rreq, raddr,
    input  wack, rack, rdata
  );

  // The register bank answers each request one cycle later
  modport regs (
    input  wreq, waddr, wdata, rreq, raddr,
    output wack, rack, rdata
  );

endinterface

// ==== rtl/axi_intr_monitor.sv ====
`timescale 1ns/100ps

module axi_intr_monitor (
  output logic                                     irq,
  input  logic                                     s_axi_aclk,
  input  logic                                     s_axi_aresetn,
  input  logic                                     s_axi_awvalid,
  input  logic [intr_mon_regs_pkg::addr_width-1:0] s_axi_awaddr,
  input  logic [intr_mon_regs_pkg::prot_width-1:0] s_axi_awprot,
  output logic                                     s_axi_awready,
  input  logic                                     s_axi_wvalid,
  input  logic [intr_mon_regs_pkg::data_width-1:0] s_axi_wdata,
  input  logic [intr_mon_regs_pkg::strb_width-1:0] s_axi_wstrb,
  output logic                                     s_axi_wready,
  output logic                                     s_axi_bvalid,
  output logic [1:0]                               s_axi_bresp,
  input  logic                                     s_axi_bready,
  input  logic                                     s_axi_arvalid,
  input  logic [intr_mon_regs_pkg::addr_width-1:0] s_axi_araddr,
  input  logic [intr_mon_regs_pkg::prot_width-1:0] s_axi_arprot,
  output logic                                     s_axi_arready,
  output logic                                     s_axi_rvalid,
  output logic [1:0]                               s_axi_rresp,
  output logic [intr_mon_regs_pkg::data_width-1:0] s_axi_rdata,
  input  logic                                     s_axi_rready
);

  // Register requests from the bridge and control between the back stages
  up_bus_if     up_bus ();
  intr_timer_if tmr_bus ();

  // The interrupt level comes straight from the register bank
  assign irq = tmr_bus.irq;

  // ********************
  // Pipeline stages
  // ********************

  // AXI4-Lite side, turns transfers into request strobes
  up_axi_bridge u_up_axi_bridge (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awprot  (s_axi_awprot),
    .s_axi_awready (s_axi_awready),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bready  (s_axi_bready),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arprot  (s_axi_arprot),
    .s_axi_arready (s_axi_arready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rready  (s_axi_rready),
    .up            (up_bus.bridge)
  );

  // Register decode and the interrupt line
  intr_mon_regs u_intr_mon_regs (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .up            (up_bus.regs),
    .tmr           (tmr_bus.regs)
  );

  // Countdown and handling time statistics
  intr_mon_timer u_intr_mon_timer (
    .s_axi_aclk    (s_axi_aclk),
    .s_axi_aresetn (s_axi_aresetn),
    .tmr           (tmr_bus.timer)
  );

endmodule

// ==== rtl/intr_mon_regs.sv ====
`timescale 1ns/100ps

module intr_mon_regs (
  input  logic        s_axi_aclk,
  input  logic        s_axi_aresetn,
  up_bus_if.regs      up,
  intr_timer_if.regs  tmr
);

  logic [intr_mon_regs_pkg::data_width-1:0]    scratch;
  logic [intr_mon_regs_pkg::data_width-1:0]    control;
  logic [intr_mon_regs_pkg::reg_sel_width-1:0] wsel;
  logic [intr_mon_regs_pkg::reg_sel_width-1:0] rsel;
  logic                                        status_clear;
  logic                                        disable_write;

  // Only the low word address bits are decoded, so the map repeats
  assign wsel = up.waddr[intr_mon_regs_pkg::reg_sel_width-1:0];
  assign rsel = up.raddr[intr_mon_regs_pkg::reg_sel_width-1:0];

  // Control bit 0 switches the whole monitor on
  assign tmr.enable = control[0];

  // Writing a one to status bit 0 acknowledges the interrupt
  assign status_clear = up.wreq && (wsel == intr_mon_regs_pkg::reg_status) && up.wdata[0];

  // A control write with bit 0 low drops the interrupt in the same cycle as enable
  assign disable_write = up.wreq && (wsel == intr_mon_regs_pkg::reg_control) && !up.wdata[0];

  // ********************
  // Write side
  // ********************

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      up.wack        <= 1'b0;
      tmr.arm        <= 1'b0;
      scratch        <= '0;
      control        <= '0;
      tmr.load_value <= '0;
    end else begin
      // Every request is acknowledged in the following cycle
      up.wack <= up.wreq;
      tmr.arm <= 1'b0;
      if (up.wreq && wsel == intr_mon_regs_pkg::reg_scratch) begin
        scratch <= up.wdata;
      end
      if (up.wreq && wsel == intr_mon_regs_pkg::reg_control) begin
        control <= up.wdata;
      end
      // A load write also arms the countdown
      if (up.wreq && wsel == intr_mon_regs_pkg::reg_count_load) begin
        tmr.load_value <= up.wdata;
        tmr.arm        <= 1'b1;
      end
    end
  end

  // Disable wins over a clear, and a clear wins over a new expiry
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !tmr.enable || disable_write) begin
      tmr.irq <= 1'b0;
    end else if (status_clear) begin
      tmr.irq <= 1'b0;
    end else if (tmr.expired) begin
      tmr.irq <= 1'b1;
    end
  end

  // ********************
  // Read side
  // ********************

  // Data is only driven during the acknowledge cycle and is zero otherwise
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      up.rack  <= 1'b0;
      up.rdata <= '0;
    end else begin
      up.rack <= up.rreq;
      if (up.rreq) begin
        case (rsel)
          intr_mon_regs_pkg::reg_version:       up.rdata <= intr_mon_regs_pkg::version_value;
          intr_mon_regs_pkg::reg_scratch:       up.rdata <= scratch;
          intr_mon_regs_pkg::reg_control:       up.rdata <= control;
          intr_mon_regs_pkg::reg_status:        up.rdata <= {31'd0, tmr.irq};
          intr_mon_regs_pkg::reg_count_load:    up.rdata <= tmr.load_value;
          intr_mon_regs_pkg::reg_since_irq:     up.rdata <= tmr.since_irq;
          intr_mon_regs_pkg::reg_handling_last: up.rdata <= tmr.handling_last;
          intr_mon_regs_pkg::reg_handling_min:  up.rdata <= tmr.handling_min;
          intr_mon_regs_pkg::reg_handling_max:  up.rdata <= tmr.handling_max;
          default:                              up.rdata <= '0;
        endcase
      end else begin
        up.rdata <= '0;
      end
    end
  end

  // The interrupt never shows while the monitor is disabled
  a_irq_disabled: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    !tmr.enable |-> !tmr.irq);

endmodule

// ==== rtl/intr_mon_timer.sv ====
`timescale 1ns/100ps

module intr_mon_timer (
  input  logic        s_axi_aclk,
  input  logic        s_axi_aresetn,
  intr_timer_if.timer tmr
);

  logic [intr_mon_types_pkg::cnt_width-1:0] count;
  logic                                     active;
  logic                                     irq_d;
  logic                                     irq_rise;
  logic                                     irq_fall;
  logic                                     event_seen;

  // Edges of the interrupt line as seen one cycle apart
  assign irq_rise = tmr.irq && !irq_d;
  assign irq_fall = !tmr.irq && irq_d;

  // An armed countdown that has run down to zero
  assign tmr.expired = active && (count == '0);

  // ********************
  // Countdown and statistics
  // ********************

  // A disabled monitor keeps everything at its reset value
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn || !tmr.enable) begin
      count             <= '0;
      active            <= 1'b0;
      irq_d             <= 1'b0;
      event_seen        <= 1'b0;
      tmr.since_irq     <= '0;
      tmr.handling_last <= '0;
      tmr.handling_min  <= intr_mon_types_pkg::min_reset_value;
      tmr.handling_max  <= intr_mon_types_pkg::max_reset_value;
    end else begin
      irq_d <= tmr.irq;

      // Arming reloads even a running countdown
      if (tmr.arm) begin
        count  <= tmr.load_value;
        active <= 1'b1;
      end else if (count != '0) begin
        count <= count - 1'b1;
      end else begin
        active <= 1'b0;
      end

      // Free running since the latest rising edge
      if (irq_rise) begin
        tmr.since_irq <= '0;
      end else begin
        tmr.since_irq <= tmr.since_irq + 1'b1;
      end

      // The count at the falling edge is the handling time of this event
      if (irq_fall) begin
        event_seen        <= 1'b1;
        tmr.handling_last <= tmr.since_irq;
        if (tmr.since_irq < tmr.handling_min) begin
          tmr.handling_min <= tmr.since_irq;
        end
        if (tmr.since_irq > tmr.handling_max) begin
          tmr.handling_max <= tmr.since_irq;
        end
      end
    end
  end

  // Both extremes come from the same recorded events
  a_min_le_max: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    event_seen |-> tmr.handling_min <= tmr.handling_max);

endmodule

// ==== up_axi/up_axi_bridge.sv ====
`timescale 1ns/100ps

module up_axi_bridge (
  input  logic                                     s_axi_aclk,
  input  logic                                     s_axi_aresetn,
  input  logic                                     s_axi_awvalid,
  input  logic [intr_mon_regs_pkg::addr_width-1:0] s_axi_awaddr,
  input  logic [intr_mon_regs_pkg::prot_width-1:0] s_axi_awprot,
  output logic                                     s_axi_awready,
  input  logic                                     s_axi_wvalid,
  input  logic [intr_mon_regs_pkg::data_width-1:0] s_axi_wdata,
  input  logic [intr_mon_regs_pkg::strb_width-1:0] s_axi_wstrb,
  output logic                                     s_axi_wready,
  output logic                                     s_axi_bvalid,
  output logic [1:0]                               s_axi_bresp,
  input  logic                                     s_axi_bready,
  input  logic                                     s_axi_arvalid,
  input  logic [intr_mon_regs_pkg::addr_width-1:0] s_axi_araddr,
  input  logic [intr_mon_regs_pkg::prot_width-1:0] s_axi_arprot,
  output logic                                     s_axi_arready,
  output logic                                     s_axi_rvalid,
  output logic [1:0]                               s_axi_rresp,
  output logic [intr_mon_regs_pkg::data_width-1:0] s_axi_rdata,
  input  logic                                     s_axi_rready,
  up_bus_if.bridge                                 up
);

  // Both directions walk through the same four states
  typedef enum logic [1:0] {st_idle, st_req, st_wait, st_resp} xfer_state_t;

  xfer_state_t wr_state;
  xfer_state_t rd_state;

  // Protection bits and write strobes are accepted and ignored, every
  // write updates the full register word
  assign s_axi_bresp = intr_mon_regs_pkg::resp_okay;
  assign s_axi_rresp = intr_mon_regs_pkg::resp_okay;

  // ********************
  // Write channel
  // ********************

  // Idle waits for address and data together, the ready pulse completes
  // the handshake, then one request goes out and the response is held
  // until the master takes it
  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      wr_state      <= st_idle;
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
      up.wreq       <= 1'b0;
    end else begin
      case (wr_state)
        st_idle: begin
          if (s_axi_awvalid && s_axi_wvalid) begin
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
            wr_state      <= st_req;
          end
        end
        st_req: begin
          s_axi_awready <= 1'b0;
          s_axi_wready  <= 1'b0;
          up.wreq       <= 1'b1;
          wr_state      <= st_wait;
        end
        st_wait: begin
          up.wreq <= 1'b0;
          if (up.wack) begin
            s_axi_bvalid <= 1'b1;
            wr_state     <= st_resp;
          end
        end
        default: begin
          if (s_axi_bready) begin
            s_axi_bvalid <= 1'b0;
            wr_state     <= st_idle;
          end
        end
      endcase
    end
  end

  // Address and data are captured in the handshake cycle
  always_ff @(posedge s_axi_aclk) begin
    if (wr_state == st_req) begin
      up.waddr <= s_axi_awaddr[intr_mon_regs_pkg::up_addr_width+1:2];
      up.wdata <= s_axi_wdata;
    end
  end

  // ********************
  // Read channel
  // ********************

  always_ff @(posedge s_axi_aclk) begin
    if (!s_axi_aresetn) begin
      rd_state      <= st_idle;
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
      up.rreq       <= 1'b0;
    end else begin
      case (rd_state)
        st_idle: begin
          if (s_axi_arvalid) begin
            s_axi_arready <= 1'b1;
            rd_state      <= st_req;
          end
        end
        st_req: begin
          s_axi_arready <= 1'b0;
          up.rreq       <= 1'b1;
          rd_state      <= st_wait;
        end
        st_wait: begin
          up.rreq <= 1'b0;
          if (up.rack) begin
            s_axi_rvalid <= 1'b1;
            rd_state     <= st_resp;
          end
        end
        default: begin
          if (s_axi_rready) begin
            s_axi_rvalid <= 1'b0;
            rd_state     <= st_idle;
          end
        end
      endcase
    end
  end

  // Read address is taken at the handshake, read data with the acknowledge
  // and held there while the master stalls
  always_ff @(posedge s_axi_aclk) begin
    if (rd_state == st_req) begin
      up.raddr <= s_axi_araddr[intr_mon_regs_pkg::up_addr_width+1:2];
    end
    if (rd_state == st_wait && up.rack) begin
      s_axi_rdata <= up.rdata;
    end
  end

  // ********************
  // Assertions
  // ********************

  // A write response may only retire through bready
  a_bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

  // The register bank sees one isolated pulse per write
  a_wreq_pulse: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
    up.wreq |=> !up.wreq);

endmodule

// ==== verif/tb_axi_tasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

// ********************
// Reference model
// ********************

// Register contents as software should see them
logic [31:0] m_scratch = '0;
logic [31:0] m_control = '0;
logic [31:0] m_load    = '0;
logic [31:0] m_last    = '0;
logic [31:0] m_max     = '0;
// The minimum starts at all ones until a first event is recorded
logic [31:0] m_min     = '1;
logic        m_irq     = 1'b0;

// Expected read data for one word offset
function automatic logic [31:0] expected_read(input logic [3:0] off);
  case (off)
    intr_mon_regs_pkg::reg_version:       return intr_mon_regs_pkg::version_value;
    intr_mon_regs_pkg::reg_scratch:       return m_scratch;
    intr_mon_regs_pkg::reg_control:       return m_control;
    intr_mon_regs_pkg::reg_status:        return {31'd0, m_irq};
    intr_mon_regs_pkg::reg_count_load:    return m_load;
    intr_mon_regs_pkg::reg_handling_last: return m_last;
    intr_mon_regs_pkg::reg_handling_min:  return m_min;
    intr_mon_regs_pkg::reg_handling_max:  return m_max;
    // Unmapped offsets, and since_irq which is only known while disabled
    default:                              return '0;
  endcase
endfunction

// Follow a register write in the model
function automatic void model_write(input logic [3:0] off, input logic [31:0] data);
  case (off)
    intr_mon_regs_pkg::reg_scratch:    m_scratch = data;
    intr_mon_regs_pkg::reg_control:    m_control = data;
    intr_mon_regs_pkg::reg_count_load: m_load = data;
    intr_mon_regs_pkg::reg_status:     m_irq = data[0] ? 1'b0 : m_irq;
    default: ;
  endcase
  // A disabled monitor drops irq and puts every statistic back to reset
  if (!m_control[0]) begin
    m_irq  = 1'b0;
    m_last = '0;
    m_min  = '1;
    m_max  = '0;
  end
endfunction

// One handling time as read back after a clear
function automatic void model_event(input logic [31:0] hl);
  m_last = hl;
  if (hl < m_min) begin
    m_min = hl;
  end
  if (hl > m_max) begin
    m_max = hl;
  end
endfunction

// ********************
// Checks and bus tasks
// ********************

task automatic check(input logic [31:0] actual, input logic [31:0] expected, input string msg);
  checks++;
  if (actual !== expected) begin
    errors++;
    $display("Mismatch at %0t: %s, read %h, expected %h", $time, msg, actual, expected);
  end
endtask

// Every bus task starts and ends right after a rising edge
task automatic axi_write(input logic [3:0] off, input logic [31:0] data);
  int delay;
  s_axi_awaddr  <= {26'd0, off, 2'b00};
  s_axi_awvalid <= 1'b1;
  s_axi_wdata   <= data;
  s_axi_wvalid  <= 1'b1;
  @(posedge s_axi_aclk);
  while (!(s_axi_awready && s_axi_wready)) @(posedge s_axi_aclk);
  s_axi_awvalid <= 1'b0;
  s_axi_wvalid  <= 1'b0;
  while (!s_axi_bvalid) @(posedge s_axi_aclk);
  bvalid_cycle = cycle;
  check(s_axi_bresp, intr_mon_regs_pkg::resp_okay, "bresp");
  model_write(off, data);
  // The response must stay up for as long as bready is held low
  delay = $urandom_range(max_delay, 0);
  repeat (delay) begin
    @(posedge s_axi_aclk);
    check(s_axi_bvalid, 1'b1, "bvalid held under back-pressure");
  end
  s_axi_bready <= 1'b1;
  @(posedge s_axi_aclk);
  check(s_axi_bvalid, 1'b1, "bvalid at the handshake");
  s_axi_bready <= 1'b0;
endtask

task automatic axi_read(input logic [3:0] off, output logic [31:0] data);
  int delay;
  s_axi_araddr  <= {26'd0, off, 2'b00};
  s_axi_arvalid <= 1'b1;
  @(posedge s_axi_aclk);
  while (!s_axi_arready) @(posedge s_axi_aclk);
  s_axi_arvalid <= 1'b0;
  while (!s_axi_rvalid) @(posedge s_axi_aclk);
  data = s_axi_rdata;
  check(s_axi_rresp, intr_mon_regs_pkg::resp_okay, "rresp");
  // Data and valid hold still while rready is low
  delay = $urandom_range(max_delay, 0);
  repeat (delay) begin
    @(posedge s_axi_aclk);
    check(s_axi_rvalid, 1'b1, "rvalid held under back-pressure");
    check(s_axi_rdata, data, "rdata held under back-pressure");
  end
  s_axi_rready <= 1'b1;
  @(posedge s_axi_aclk);
  check(s_axi_rvalid, 1'b1, "rvalid at the handshake");
  s_axi_rready <= 1'b0;
endtask

task automatic read_compare(input logic [3:0] off, input string what);
  logic [31:0] data;
  axi_read(off, data);
  check(data, expected_read(off), what);
endtask

`endif

// ==== verif/tb_axi_intr_monitor.sv ====
`timescale 1ns/100ps

module tb_axi_intr_monitor;

  // Clock period in ns and the number of cycles each test may take
  localparam int clk_period  = 100;
  localparam int num_tests   = 6;
  localparam int test_budget = 2000;

  logic        s_axi_aclk;
  logic        s_axi_aresetn;
  logic        s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready;
  logic        s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready, s_axi_rvalid;
  logic        irq;
  logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr, s_axi_rdata;
  logic [2:0]  s_axi_awprot, s_axi_arprot;
  logic [3:0]  s_axi_wstrb;
  logic [1:0]  s_axi_bresp, s_axi_rresp;

  // Cycle stamps shared by the bus tasks and the tests
  int unsigned cycle = 0;
  int unsigned bvalid_cycle = 0;
  int unsigned irq_rise_cycle = 0;
  logic        irq_q = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          failed_tests = 0;
  int          max_delay = 3;

  `include "tb_axi_tasks.svh"

  axi_intr_monitor u_dut (.*);

  initial begin
    s_axi_aclk = 1'b0;
    forever #(clk_period / 2) s_axi_aclk = ~s_axi_aclk;
  end

  // Cycle count and the cycle in which irq was first seen high
  always @(posedge s_axi_aclk) begin
    cycle <= cycle + 1;
    irq_q <= irq;
    if (irq && !irq_q) begin
      irq_rise_cycle <= cycle;
    end
  end

  initial begin
    #(test_budget * num_tests * clk_period);
    $display("Timeout: the tests did not finish within %0d cycles", test_budget * num_tests);
    $display("** FAIL **");
    $finish;
  end

  // Arm a random countdown and check when irq comes up
  task automatic arm_and_check_rise();
    logic [31:0] n;
    int unsigned rise_delay;
    n = $urandom_range(40, 4);
    axi_write(intr_mon_regs_pkg::reg_count_load, n);
    while (!irq && cycle < bvalid_cycle + n + 8) @(posedge s_axi_aclk);
    @(posedge s_axi_aclk);
    if (!irq) begin
      errors++;
      $display("Error at %0t: irq did not rise within %0d cycles of the load write", $time, n + 8);
    end else begin
      rise_delay = irq_rise_cycle - bvalid_cycle;
      check(rise_delay >= n && rise_delay <= n + 8, 1'b1, "irq rise delay after bvalid");
    end
    m_irq = 1'b1;
    read_compare(intr_mon_regs_pkg::reg_status, "status after expiry");
  endtask

  // Clear after a random wait and record the handling time in the model
  task automatic clear_and_record(input int max_wait);
    logic [31:0] hl;
    repeat ($urandom_range(max_wait, 0)) @(posedge s_axi_aclk);
    axi_write(intr_mon_regs_pkg::reg_status, 32'd1);
    check(irq, 1'b0, "irq after clear");
    read_compare(intr_mon_regs_pkg::reg_status, "status after clear");
    axi_read(intr_mon_regs_pkg::reg_handling_last, hl);
    check(hl <= bvalid_cycle - irq_rise_cycle, 1'b1, "handling_last within counted cycles");
    model_event(hl);
  endtask

  task automatic report_test(input int num, input string name, input int start_errors);
    if (errors == start_errors) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: failed with %0d errors", num, name, errors - start_errors);
    end
  endtask

  initial begin
    logic [31:0] data;
    int          start_errors;
    int          i;
    void'($urandom(40));
    s_axi_aresetn <= 1'b0;
    {s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready} <= '0;
    s_axi_awaddr  <= '0;
    s_axi_araddr  <= '0;
    s_axi_wdata   <= '0;
    s_axi_awprot  <= '0;
    s_axi_arprot  <= '0;
    s_axi_wstrb   <= '1;
    repeat (3) @(posedge s_axi_aclk);
    s_axi_aresetn <= 1'b1;

    start_errors = errors;
    // Handshake outputs and the interrupt come out of reset low
    check({s_axi_awready, s_axi_wready, s_axi_arready, s_axi_bvalid, s_axi_rvalid, irq},
          32'd0, "outputs after reset");
    read_compare(intr_mon_regs_pkg::reg_version, "version");
    data = $urandom;
    axi_write(intr_mon_regs_pkg::reg_scratch, data);
    read_compare(intr_mon_regs_pkg::reg_scratch, "scratch readback");
    read_compare(4'hc, "unmapped offset");
    report_test(1, "register access", start_errors);

    // Arming while disabled must leave irq and every statistic alone
    start_errors = errors;
    axi_write(intr_mon_regs_pkg::reg_control, 32'd0);
    data = $urandom_range(40, 4);
    axi_write(intr_mon_regs_pkg::reg_count_load, data);
    repeat (data + 8) begin
      @(posedge s_axi_aclk);
      check(irq, 1'b0, "irq while disabled");
    end
    for (i = intr_mon_regs_pkg::reg_since_irq; i <= intr_mon_regs_pkg::reg_handling_max; i++) begin
      read_compare(4'(i), "statistics while disabled");
    end
    report_test(2, "disabled monitor", start_errors);

    start_errors = errors;
    axi_write(intr_mon_regs_pkg::reg_control, 32'd1);
    arm_and_check_rise();
    report_test(3, "countdown expiry", start_errors);

    start_errors = errors;
    clear_and_record(20);
    report_test(4, "interrupt clear", start_errors);

    start_errors = errors;
    repeat (4) begin
      arm_and_check_rise();
      clear_and_record(30);
    end
    read_compare(intr_mon_regs_pkg::reg_handling_min, "handling_min");
    read_compare(intr_mon_regs_pkg::reg_handling_max, "handling_max");
    report_test(5, "handling statistics", start_errors);

    // Long random stalls on bready and rready
    start_errors = errors;
    max_delay = 12;
    repeat (4) begin
      data = $urandom;
      axi_write(intr_mon_regs_pkg::reg_scratch, data);
      read_compare(intr_mon_regs_pkg::reg_scratch, "scratch under back-pressure");
      read_compare(intr_mon_regs_pkg::reg_control, "control under back-pressure");
      read_compare(intr_mon_regs_pkg::reg_handling_max, "handling_max under back-pressure");
    end
    max_delay = 3;
    report_test(6, "back-pressure", start_errors);

    $display("Summary: %0d of %0d tests failed, %0d checks, %0d errors",
             failed_tests, num_tests, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
